// File: vlog.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/decoder.sv
rtl/regfile.sv
rtl/alu.sv
rtl/data_mem.sv
rtl/regwalls.sv
rtl/cpu_top.sv
tests/tb_clock.sv
tests/cpu_tb.sv

// File: Makefile
SIM_LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f vlog.f --top-module cpu_tb -Mdir obj_dir -o cpu_sim

run: compile
	-./obj_dir/cpu_sim > $(SIM_LOG) 2>&1
	@cat $(SIM_LOG)
	@if grep -q "TEST FAILED" $(SIM_LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "TEST OK" $(SIM_LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(SIM_LOG)

// File: tests/cpu_tb.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_tb;
	import cpu_pkg::*;

	localparam int MAX_PROG = 64;

	logic                    clock;
	logic                    rst;
	logic                    reset_req;
	logic [`CPU_XLEN-1:0]    imem_data;
	logic [`CPU_IMEM_AW-1:0] imem_addr;
	logic                    wb_valid;
	logic [`CPU_REG_AW-1:0]  wb_addr;
	logic [`CPU_XLEN-1:0]    wb_data;
	logic                    overflow;

	logic [31:0] prog [0:(1<<`CPU_IMEM_AW)-1];
	logic [31:0] model [0:31];
	logic [31:0] dm_model [0:255];
	logic [31:0] rand_state;
	int          prog_len;
	int          spacing;
	int          total_cycles;
	int          cycle_limit;
	string       test_name;

	int          exp_cyc[$];
	logic [4:0]  exp_addr[$];
	logic [31:0] exp_data[$];
	int          exp_ovf[$];
	int          got_cyc[$];
	logic [4:0]  got_addr[$];
	logic [31:0] got_data[$];
	int          got_ovf[$];

	tb_clock clock_gen_i (.reset_req(reset_req), .clock(clock), .rst(rst));

	assign imem_data = prog[imem_addr];

	cpu_top cpu_top_i (
		.clock     (clock),
		.rst       (rst),
		.imem_data (imem_data),
		.imem_addr (imem_addr),
		.wb_valid  (wb_valid),
		.wb_addr   (wb_addr),
		.wb_data   (wb_data),
		.overflow  (overflow)
	);

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else
			report_failure($sformatf("MISMATCH %s %s expected %h actual %h",
				test_name, what, expected, actual));
	endtask

	always @(posedge clock) begin
		total_cycles++;
		if (total_cycles > cycle_limit) begin
			report_failure("timeout, the run took more cycles than the tests allow");
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function logic [31:0] next_random();
		rand_state = xorshift(rand_state);
		return rand_state;
	endfunction

	function automatic logic [31:0] sext14(input logic [13:0] v);
		return {{18{v[13]}}, v};
	endfunction

	// true when the exact result does not fit in 32 signed bits
	function automatic logic out_of_range(input longint v);
		return v != longint'(int'(v));
	endfunction

	// bit 31 of every encoding stays zero
	function automatic logic [31:0] encode_reg(input alu_op_t sub, input logic [4:0] rt,
			input logic [4:0] ra, input logic [4:0] rb);
		return {1'b0, ALU_REG, rt, ra, rb, 5'b0, sub};
	endfunction

	function automatic logic [31:0] encode_imm(input opcode_t op, input logic [4:0] rt,
			input logic [4:0] ra, input logic [13:0] imm);
		return {1'b0, op, rt, ra, 1'b0, imm};
	endfunction

	task automatic emit(input logic [31:0] instr);
		assert (prog_len < MAX_PROG) else
			report_failure("program does not fit the test program area");
		prog[prog_len[`CPU_IMEM_AW-1:0]] = instr;
		prog_len++;
		for (int i = 0; i < spacing; i++) begin
			prog[prog_len[`CPU_IMEM_AW-1:0]] = 32'h0;
			prog_len++;
		end
	endtask

	// write-back lands four cycles after fetch
	task automatic expect_wb(input logic [4:0] rt, input logic [31:0] value);
		exp_cyc.push_back(prog_len + 4);
		exp_addr.push_back(rt);
		exp_data.push_back(value);
		if (rt != 0) begin
			model[rt] = value;
		end
	endtask

	task automatic op_reg(input alu_op_t sub, input logic [4:0] rt, input logic [4:0] ra,
			input logic [4:0] rb);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic        ov;
		a = model[ra];
		b = model[rb];
		ov = 1'b0;
		case (sub)
			ADD: begin
				r = a + b;
				ov = out_of_range(longint'($signed(a)) + longint'($signed(b)));
			end
			SUB: begin
				r = a - b;
				ov = out_of_range(longint'($signed(a)) - longint'($signed(b)));
			end
			AND: r = a & b;
			OR:  r = a | b;
			XOR: r = a ^ b;
			default: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		endcase
		if (ov) begin
			exp_ovf.push_back(prog_len + 3);
		end
		expect_wb(rt, r);
		emit(encode_reg(sub, rt, ra, rb));
	endtask

	task automatic op_addi(input logic [4:0] rt, input logic [4:0] ra, input logic [13:0] imm);
		logic [31:0] a;
		logic [31:0] r;
		a = model[ra];
		r = a + sext14(imm);
		if (out_of_range(longint'($signed(a)) + longint'($signed(sext14(imm))))) begin
			exp_ovf.push_back(prog_len + 3);
		end
		expect_wb(rt, r);
		emit(encode_imm(ADDI, rt, ra, imm));
	endtask

	task automatic op_ori(input logic [4:0] rt, input logic [4:0] ra, input logic [13:0] imm);
		expect_wb(rt, model[ra] | {18'b0, imm});
		emit(encode_imm(ORI, rt, ra, imm));
	endtask

	task automatic op_movi(input logic [4:0] rt, input logic [19:0] imm);
		expect_wb(rt, {{12{imm[19]}}, imm});
		emit({1'b0, MOVI, rt, imm});
	endtask

	task automatic op_lwi(input logic [4:0] rt, input logic [4:0] ra, input logic [13:0] off);
		logic [31:0] addr;
		addr = model[ra] + (sext14(off) << 2);
		expect_wb(rt, dm_model[addr[9:2]]);
		emit(encode_imm(LWI, rt, ra, off));
	endtask

	task automatic op_swi(input logic [4:0] rt, input logic [4:0] ra, input logic [13:0] off);
		logic [31:0] addr;
		addr = model[ra] + (sext14(off) << 2);
		dm_model[addr[9:2]] = model[rt];
		emit(encode_imm(SWI, rt, ra, off));
	endtask

	task automatic begin_program();
		for (int i = 0; i < (1 << `CPU_IMEM_AW); i++) begin
			prog[i] = 32'h0;
		end
		for (int i = 0; i < 32; i++) begin
			model[i] = 32'h0;
		end
		prog_len = 0;
		spacing = 2;
		exp_cyc.delete();
		exp_addr.delete();
		exp_data.delete();
		exp_ovf.delete();
	endtask

	task automatic reset_cpu();
		reset_req = 1'b1;
		@(posedge clock);
		#1 reset_req = 1'b0;
		@(negedge rst);
	endtask

	task automatic run_program(input string name);
		int run_len;
		test_name = name;
		cycle_limit += prog_len + 40;
		got_cyc.delete();
		got_addr.delete();
		got_data.delete();
		got_ovf.delete();
		reset_cpu();
		run_len = prog_len + 8;
		for (int c = 0; c < run_len; c++) begin
			check_value("imem_addr", c, 32'(imem_addr));
			if (wb_valid) begin
				got_cyc.push_back(c);
				got_addr.push_back(wb_addr);
				got_data.push_back(wb_data);
			end
			if (overflow) begin
				got_ovf.push_back(c);
			end
			@(posedge clock);
			#1;
		end
		check_value("write-back count", exp_cyc.size(), got_cyc.size());
		for (int i = 0; i < exp_cyc.size(); i++) begin
			check_value($sformatf("wb %0d cycle", i), exp_cyc[i], got_cyc[i]);
			check_value($sformatf("wb %0d addr", i), 32'(exp_addr[i]), 32'(got_addr[i]));
			check_value($sformatf("wb %0d data", i), exp_data[i], got_data[i]);
		end
		check_value("overflow count", exp_ovf.size(), got_ovf.size());
		for (int i = 0; i < exp_ovf.size(); i++) begin
			check_value($sformatf("overflow %0d cycle", i), exp_ovf[i], got_ovf[i]);
		end
	endtask

	task automatic test_reset();
		begin_program();
		op_movi(5'd1, 20'h12345);
		run_program("test_reset");
	endtask

	task automatic test_alu_ops();
		alu_op_t     ops [0:5];
		logic [31:0] r;
		ops = '{ADD, SUB, AND, OR, XOR, SLT};
		begin_program();
		for (int i = 1; i <= 4; i++) begin
			r = next_random();
			op_movi(5'(i), r[19:0]);
		end
		for (int i = 0; i < 6; i++) begin
			op_reg(ops[i], 5'(5 + i), 5'd1, 5'd2);
		end
		op_reg(SLT, 5'd11, 5'd2, 5'd1);
		op_reg(SUB, 5'd12, 5'd3, 5'd4);
		op_reg(XOR, 5'd13, 5'd4, 5'd3);
		run_program("test_alu_ops");
	endtask

	task automatic test_immediates();
		logic [31:0] r;
		begin_program();
		r = next_random();
		op_movi(5'd1, r[19:0]);
		op_addi(5'd2, 5'd1, 14'h3F00);
		op_addi(5'd3, 5'd0, 14'h3FFB);
		op_ori(5'd4, 5'd0, 14'h2ABC);
		op_movi(5'd5, 20'h80123);
		// writes to r0 show on write-back but leave it zero
		op_movi(5'd0, 20'h00777);
		op_addi(5'd0, 5'd1, 14'h0011);
		op_reg(ADD, 5'd6, 5'd0, 5'd5);
		op_reg(ADD, 5'd7, 5'd1, 5'd0);
		run_program("test_immediates");
	endtask

	task automatic test_load_store();
		logic [31:0] r;
		begin_program();
		for (int i = 1; i <= 5; i++) begin
			r = next_random();
			op_movi(5'(i), r[19:0]);
		end
		for (int i = 0; i < 4; i++) begin
			op_swi(5'(1 + i), 5'd0, 14'(i * 3 + 1));
		end
		for (int i = 0; i < 4; i++) begin
			op_lwi(5'(10 + i), 5'd0, 14'(i * 3 + 1));
		end
		// load two slots behind its store
		spacing = 1;
		op_swi(5'd5, 5'd0, 14'd4);
		spacing = 2;
		op_lwi(5'd14, 5'd0, 14'd4);
		run_program("test_load_store");
	endtask

	task automatic test_overflow();
		begin_program();
		op_movi(5'd1, 20'h40000);
		// doubling up to 2^30 stays in range
		for (int i = 0; i < 12; i++) begin
			op_reg(ADD, 5'd1, 5'd1, 5'd1);
		end
		op_reg(ADD, 5'd2, 5'd1, 5'd1);
		op_movi(5'd3, 20'h00001);
		op_reg(SUB, 5'd4, 5'd2, 5'd3);
		op_reg(ADD, 5'd5, 5'd3, 5'd3);
		run_program("test_overflow");
	endtask

	task automatic test_dependency_spacing();
		logic [31:0] r;
		begin_program();
		r = next_random();
		op_movi(5'd1, r[19:0]);
		for (int i = 0; i < 8; i++) begin
			r = next_random();
			op_addi(5'd1, 5'd1, {1'b0, r[12:0]});
		end
		run_program("test_dependency_spacing");
	endtask

	initial begin
		reset_req = 1'b0;
		rand_state = 32'd20;
		total_cycles = 0;
		cycle_limit = 40;
		spacing = 2;
		prog_len = 0;
		for (int i = 0; i < 256; i++) begin
			dm_model[i] = 32'h0;
		end
		test_reset();
		test_alu_ops();
		test_immediates();
		test_load_store();
		test_overflow();
		test_dependency_spacing();
		$display("TEST OK");
		$finish;
	end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ns

module tb_clock(
	input  logic reset_req,
	output logic clock,
	output logic rst
);
	int hold;

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial begin
		hold = 16;
		rst = 1'b1;
	end

	// reset follows the sampled request 1 ns after the edge
	always @(posedge clock) begin
		if (reset_req) begin
			hold = 16;
		end else if (hold != 0) begin
			hold = hold - 1;
		end
		#1 rst = (hold != 0);
	end

endmodule

// File: rtl/cpu_top.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_top(
	input  logic                    clock,
	input  logic                    rst,
	input  logic [`CPU_XLEN-1:0]    imem_data,
	output logic [`CPU_IMEM_AW-1:0] imem_addr,
	output logic                    wb_valid,
	output logic [`CPU_REG_AW-1:0]  wb_addr,
	output logic [`CPU_XLEN-1:0]    wb_data,
	output logic                    overflow
);
	import cpu_pkg::*;

	// decode stage
	logic [`CPU_XLEN-1:0]   id_instruction;
	logic [`CPU_REG_AW-1:0] rf_ra_addr;
	logic [`CPU_REG_AW-1:0] rf_rb_addr;
	logic [`CPU_XLEN-1:0]   rf_ra_data;
	logic [`CPU_XLEN-1:0]   rf_rb_data;
	logic [`CPU_REG_AW-1:0] id_write_reg_addr;
	opcode_t                id_opcode;
	alu_op_t                id_sub_op_base;
	logic [`CPU_XLEN-1:0]   id_imm_extend;
	logic [`CPU_XLEN-1:0]   id_alu_src2;
	wb_sel_t                id_select_write_reg;
	logic                   id_do_dm_read;
	logic                   id_do_dm_write;
	logic                   id_do_reg_write;

	// execute stage
	logic [`CPU_XLEN-1:0]   ex_ra_data;
	logic [`CPU_XLEN-1:0]   ex_alu_src2;
	opcode_t                ex_opcode;
	alu_op_t                ex_sub_op_base;
	logic [`CPU_XLEN-1:0]   alu_result;
	logic                   alu_overflow;

	// memory stage
	logic [`CPU_XLEN-1:0]   mem_addr;
	logic [`CPU_XLEN-1:0]   mem_wdata;
	logic                   mem_we;
	logic [`CPU_XLEN-1:0]   dm_rdata;

	regwalls regwalls_i (
		.clock            (clock),
		.rst              (rst),
		.pc               (imem_addr),
		.instruction_in   (imem_data),
		.instruction      (id_instruction),
		.ra_data_in       (rf_ra_data),
		.rt_data          (rf_rb_data),
		.alu_src2_in      (id_alu_src2),
		.imm_extend       (id_imm_extend),
		.ra_data          (ex_ra_data),
		.alu_src2         (ex_alu_src2),
		.write_reg_addr   (id_write_reg_addr),
		.opcode_in        (id_opcode),
		.sub_op_base_in   (id_sub_op_base),
		.opcode           (ex_opcode),
		.sub_op_base      (ex_sub_op_base),
		.select_write_reg (id_select_write_reg),
		.do_dm_read       (id_do_dm_read),
		.do_dm_write      (id_do_dm_write),
		.do_reg_write     (id_do_reg_write),
		.alu_result       (alu_result),
		.alu_overflow     (alu_overflow),
		.mem_addr         (mem_addr),
		.mem_wdata        (mem_wdata),
		.mem_we           (mem_we),
		.overflow         (overflow),
		.dm_rdata         (dm_rdata),
		.wb_valid         (wb_valid),
		.wb_addr          (wb_addr),
		.wb_data          (wb_data)
	);

	// raw immediates are folded into imm_extend inside the decoder
	decoder decoder_i (
		.instruction      (id_instruction),
		.rb_data          (rf_rb_data),
		.ra_addr          (rf_ra_addr),
		.rb_addr          (rf_rb_addr),
		.write_reg_addr   (id_write_reg_addr),
		.opcode           (id_opcode),
		.sub_op_base      (id_sub_op_base),
		.imm_14bit        (),
		.imm_20bit        (),
		.imm_extend       (id_imm_extend),
		.alu_src2         (id_alu_src2),
		.select_write_reg (id_select_write_reg),
		.do_dm_read       (id_do_dm_read),
		.do_dm_write      (id_do_dm_write),
		.do_reg_write     (id_do_reg_write)
	);

	regfile regfile_i (
		.clock   (clock),
		.rst     (rst),
		.ra_addr (rf_ra_addr),
		.rb_addr (rf_rb_addr),
		.we      (wb_valid),
		.waddr   (wb_addr),
		.wdata   (wb_data),
		.ra_data (rf_ra_data),
		.rb_data (rf_rb_data)
	);

	alu alu_i (
		.op       (ex_sub_op_base),
		.opcode   (ex_opcode),
		.a        (ex_ra_data),
		.b        (ex_alu_src2),
		.result   (alu_result),
		.overflow (alu_overflow)
	);

	data_mem data_mem_i (
		.clock (clock),
		.addr  (mem_addr),
		.we    (mem_we),
		.wdata (mem_wdata),
		.rdata (dm_rdata)
	);

endmodule

// File: rtl/regwalls.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module regwalls(
	input  logic                    clock,
	input  logic                    rst,
	output logic [`CPU_IMEM_AW-1:0] pc,
	input  logic [`CPU_XLEN-1:0]    instruction_in,
	output logic [`CPU_XLEN-1:0]    instruction,
	input  logic [`CPU_XLEN-1:0]    ra_data_in,
	input  logic [`CPU_XLEN-1:0]    rt_data,
	input  logic [`CPU_XLEN-1:0]    alu_src2_in,
	input  logic [`CPU_XLEN-1:0]    imm_extend,
	output logic [`CPU_XLEN-1:0]    ra_data,
	output logic [`CPU_XLEN-1:0]    alu_src2,
	input  logic [`CPU_REG_AW-1:0]  write_reg_addr,
	input  cpu_pkg::opcode_t        opcode_in,
	input  cpu_pkg::alu_op_t        sub_op_base_in,
	output cpu_pkg::opcode_t        opcode,
	output cpu_pkg::alu_op_t        sub_op_base,
	input  cpu_pkg::wb_sel_t        select_write_reg,
	input  logic                    do_dm_read,
	input  logic                    do_dm_write,
	input  logic                    do_reg_write,
	input  logic [`CPU_XLEN-1:0]    alu_result,
	input  logic                    alu_overflow,
	output logic [`CPU_XLEN-1:0]    mem_addr,
	output logic [`CPU_XLEN-1:0]    mem_wdata,
	output logic                    mem_we,
	output logic                    overflow,
	input  logic [`CPU_XLEN-1:0]    dm_rdata,
	output logic                    wb_valid,
	output logic [`CPU_REG_AW-1:0]  wb_addr,
	output logic [`CPU_XLEN-1:0]    wb_data
);
	import cpu_pkg::*;

	// delay chains take the name of the stage register holding them
	logic [`CPU_REG_AW-1:0] s2_write_reg_addr;
	logic [`CPU_REG_AW-1:0] s3_write_reg_addr;
	wb_sel_t                s2_select_write_reg;
	wb_sel_t                s3_select_write_reg;
	logic                   s2_do_dm_read;
	logic                   s3_do_dm_read;
	logic                   s2_do_dm_write;
	logic                   s2_do_reg_write;
	logic                   s3_do_reg_write;
	logic [`CPU_XLEN-1:0]   s2_rt_data;
	logic [`CPU_XLEN-1:0]   s2_imm_extend;
	logic [`CPU_XLEN-1:0]   s3_imm_extend;
	logic [`CPU_XLEN-1:0]   write_reg_data;

	always_ff @(posedge clock) begin
		if (rst) begin
			pc                  <= '0;
			instruction         <= NOP_INSTR;
			opcode              <= NOP;
			sub_op_base         <= ADD;
			s2_select_write_reg <= WB_ALU;
			s2_do_dm_read       <= 1'b0;
			s2_do_dm_write      <= 1'b0;
			s2_do_reg_write     <= 1'b0;
			s3_select_write_reg <= WB_ALU;
			s3_do_dm_read       <= 1'b0;
			mem_we              <= 1'b0;
			s3_do_reg_write     <= 1'b0;
			overflow            <= 1'b0;
			wb_valid            <= 1'b0;
		end else begin
			pc          <= pc + 1'b1;
			instruction <= instruction_in;

			opcode              <= opcode_in;
			sub_op_base         <= sub_op_base_in;
			s2_select_write_reg <= select_write_reg;
			s2_do_dm_read       <= do_dm_read;
			s2_do_dm_write      <= do_dm_write;
			s2_do_reg_write     <= do_reg_write;

			s3_select_write_reg <= s2_select_write_reg;
			s3_do_dm_read       <= s2_do_dm_read;
			mem_we              <= s2_do_dm_write;
			s3_do_reg_write     <= s2_do_reg_write;
			overflow            <= alu_overflow;

			wb_valid <= s3_do_reg_write;
		end
	end

	always_ff @(posedge clock) begin
		ra_data           <= ra_data_in;
		alu_src2          <= alu_src2_in;
		s2_rt_data        <= rt_data;
		s2_imm_extend     <= imm_extend;
		s2_write_reg_addr <= write_reg_addr;

		mem_addr          <= alu_result;
		mem_wdata         <= s2_rt_data;
		s3_imm_extend     <= s2_imm_extend;
		s3_write_reg_addr <= s2_write_reg_addr;

		wb_addr <= s3_write_reg_addr;
		wb_data <= write_reg_data;
	end

	// write-back select
	// mem_addr doubles as the stage-3 alu result
	always_comb begin
		case (s3_select_write_reg)
			WB_MEM:  write_reg_data = dm_rdata;
			WB_IMM:  write_reg_data = s3_imm_extend;
			default: write_reg_data = mem_addr;
		endcase
	end

	// load and store strobes come from one opcode, never both
	no_read_write_clash: assert property (
		@(posedge clock) disable iff (rst) !(s3_do_dm_read && mem_we)
	);

endmodule

// File: rtl/data_mem.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module data_mem(
	input  logic                 clock,
	input  logic [`CPU_XLEN-1:0] addr,
	input  logic                 we,
	input  logic [`CPU_XLEN-1:0] wdata,
	output logic [`CPU_XLEN-1:0] rdata
);
	logic [`CPU_XLEN-1:0]    mem [0:`CPU_DMEM_DEPTH-1];
	logic [`CPU_DMEM_AW-1:0] word_addr;

	// byte address in, word index out
	assign word_addr = addr[`CPU_DMEM_AW+1:2];

	always_ff @(posedge clock) begin
		if (we) begin
			mem[word_addr] <= wdata;
		end
	end

	assign rdata = mem[word_addr];

	// a store above the array would alias onto a low word
	store_in_range: assert property (
		@(posedge clock) we |-> (addr[`CPU_XLEN-1:`CPU_DMEM_AW+2] == '0)
	);

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module alu(
	input  cpu_pkg::alu_op_t     op,
	input  cpu_pkg::opcode_t     opcode,
	input  logic [`CPU_XLEN-1:0] a,
	input  logic [`CPU_XLEN-1:0] b,
	output logic [`CPU_XLEN-1:0] result,
	output logic                 overflow
);
	import cpu_pkg::*;

	localparam int MSB = `CPU_XLEN - 1;

	alu_op_t              eff_op;
	logic [`CPU_XLEN-1:0] sum;
	logic [`CPU_XLEN-1:0] diff;
	logic                 less;
	logic                 ovf_raw;

	// immediate forms pick their own operation
	always_comb begin
		case (opcode)
			ADDI, LWI, SWI: eff_op = ADD;
			ORI:            eff_op = OR;
			default:        eff_op = op;
		endcase
	end

	assign sum  = a + b;
	assign diff = a - b;
	assign less = $signed(a) < $signed(b);

	always_comb begin
		case (eff_op)
			ADD:     result = sum;
			SUB:     result = diff;
			AND:     result = a & b;
			OR:      result = a | b;
			XOR:     result = a ^ b;
			SLT:     result = {{(`CPU_XLEN-1){1'b0}}, less};
			default: result = '0;
		endcase
	end

	always_comb begin
		case (eff_op)
			ADD:     ovf_raw = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
			SUB:     ovf_raw = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
			default: ovf_raw = 1'b0;
		endcase
	end

	// address arithmetic and nop/movi never flag
	assign overflow = ovf_raw && (opcode == ALU_REG || opcode == ADDI);

endmodule

// File: rtl/regfile.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module regfile(
	input  logic                   clock,
	input  logic                   rst,
	input  logic [`CPU_REG_AW-1:0] ra_addr,
	input  logic [`CPU_REG_AW-1:0] rb_addr,
	input  logic                   we,
	input  logic [`CPU_REG_AW-1:0] waddr,
	input  logic [`CPU_XLEN-1:0]   wdata,
	output logic [`CPU_XLEN-1:0]   ra_data,
	output logic [`CPU_XLEN-1:0]   rb_data
);
	logic [`CPU_XLEN-1:0] regs [0:`CPU_NREGS-1];
	logic                 wr_live;

	// r0 never takes a write
	assign wr_live = we && (waddr != '0);

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < `CPU_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[waddr] <= wdata;
		end
	end

	// write-through so decode sees the value retiring this cycle
	assign ra_data = (wr_live && waddr == ra_addr) ? wdata : regs[ra_addr];
	assign rb_data = (wr_live && waddr == rb_addr) ? wdata : regs[rb_addr];

endmodule

// File: rtl/decoder.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module decoder(
	input  logic [`CPU_XLEN-1:0]   instruction,
	input  logic [`CPU_XLEN-1:0]   rb_data,
	output logic [`CPU_REG_AW-1:0] ra_addr,
	output logic [`CPU_REG_AW-1:0] rb_addr,
	output logic [`CPU_REG_AW-1:0] write_reg_addr,
	output cpu_pkg::opcode_t       opcode,
	output cpu_pkg::alu_op_t       sub_op_base,
	output logic [13:0]            imm_14bit,
	output logic [19:0]            imm_20bit,
	output logic [`CPU_XLEN-1:0]   imm_extend,
	output logic [`CPU_XLEN-1:0]   alu_src2,
	output cpu_pkg::wb_sel_t       select_write_reg,
	output logic                   do_dm_read,
	output logic                   do_dm_write,
	output logic                   do_reg_write
);
	import cpu_pkg::*;

	logic [5:0]           raw_op;
	logic                 use_rb;
	logic [`CPU_XLEN-1:0] sext14;
	logic [`CPU_XLEN-1:0] zext14;
	logic [`CPU_XLEN-1:0] sext20;

	assign raw_op         = instruction[OPC_MSB:OPC_LSB];
	assign imm_14bit      = instruction[IMM14_MSB:0];
	assign imm_20bit      = instruction[IMM20_MSB:0];
	assign write_reg_addr = instruction[RT_MSB:RT_LSB];
	assign ra_addr        = instruction[RA_MSB:RA_LSB];

	assign sext14 = {{(`CPU_XLEN-14){imm_14bit[13]}}, imm_14bit};
	assign zext14 = {{(`CPU_XLEN-14){1'b0}}, imm_14bit};
	assign sext20 = {{(`CPU_XLEN-20){imm_20bit[19]}}, imm_20bit};

	always_comb begin
		opcode           = NOP;
		sub_op_base      = ADD;
		imm_extend       = '0;
		select_write_reg = WB_ALU;
		do_dm_read       = 1'b0;
		do_dm_write      = 1'b0;
		do_reg_write     = 1'b0;
		use_rb           = 1'b0;
		case (raw_op)
			ALU_REG: begin
				opcode       = ALU_REG;
				sub_op_base  = alu_op_t'(instruction[SUB_MSB:SUB_LSB]);
				use_rb       = 1'b1;
				do_reg_write = 1'b1;
			end
			ADDI: begin
				opcode       = ADDI;
				imm_extend   = sext14;
				do_reg_write = 1'b1;
			end
			ORI: begin
				opcode       = ORI;
				imm_extend   = zext14;
				do_reg_write = 1'b1;
			end
			MOVI: begin
				opcode           = MOVI;
				imm_extend       = sext20;
				select_write_reg = WB_IMM;
				do_reg_write     = 1'b1;
			end
			// word offset scaled to a byte address
			LWI: begin
				opcode           = LWI;
				imm_extend       = {sext14[`CPU_XLEN-3:0], 2'b00};
				select_write_reg = WB_MEM;
				do_dm_read       = 1'b1;
				do_reg_write     = 1'b1;
			end
			SWI: begin
				opcode      = SWI;
				imm_extend  = {sext14[`CPU_XLEN-3:0], 2'b00};
				do_dm_write = 1'b1;
			end
			default: begin
			end
		endcase
	end

	// stores read their data register through port rb
	assign rb_addr  = (opcode == SWI) ? instruction[RT_MSB:RT_LSB] : instruction[RB_MSB:RB_LSB];
	assign alu_src2 = use_rb ? rb_data : imm_extend;

endmodule

// File: rtl/cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

	// major opcode, instruction bits 30..25
	typedef enum logic [5:0] {
		NOP     = 6'h00,
		ALU_REG = 6'h01,
		ADDI    = 6'h02,
		ORI     = 6'h03,
		MOVI    = 6'h04,
		LWI     = 6'h05,
		SWI     = 6'h06
	} opcode_t;

	typedef enum logic [4:0] {
		ADD = 5'h00,
		SUB = 5'h01,
		AND = 5'h02,
		OR  = 5'h03,
		XOR = 5'h04,
		SLT = 5'h05
	} alu_op_t;

	// write-back source
	typedef enum logic [1:0] {
		WB_ALU = 2'd0,
		WB_MEM = 2'd1,
		WB_IMM = 2'd2
	} wb_sel_t;

	localparam int OPC_MSB   = 30;
	localparam int OPC_LSB   = 25;
	localparam int RT_MSB    = 24;
	localparam int RT_LSB    = 20;
	localparam int RA_MSB    = 19;
	localparam int RA_LSB    = 15;
	localparam int RB_MSB    = 14;
	localparam int RB_LSB    = 10;
	localparam int SUB_MSB   = 4;
	localparam int SUB_LSB   = 0;
	localparam int IMM14_MSB = 13;
	localparam int IMM20_MSB = 19;

	localparam logic [`CPU_XLEN-1:0] NOP_INSTR = `CPU_XLEN'(NOP) << OPC_LSB;

endpackage

// File: rtl/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath and instruction width
`define CPU_XLEN 32

// register file
`define CPU_REG_AW 5
`define CPU_NREGS 32

// word address widths of the two memories
`define CPU_IMEM_AW 10
`define CPU_DMEM_AW 8
`define CPU_DMEM_DEPTH 256

`endif
